// File: flist.f
+incdir+rtl
rtl/mapper_pkg.sv
rtl/mapper_regs.sv
rtl/region_match.sv
rtl/access_timer.sv
rtl/dtack_select.sv
rtl/mapper_top.sv
tests/mapper_sva.sv
tests/mapper_tb.sv

// File: rtl/access_timer.sv
// ******************************
// access timer
// saturating count of clocks
// within a bus cycle
// ******************************
`timescale 1ns/1ps

module access_timer (
    input  logic       clk,
    input  logic       rst,
    input  logic       asn,
    output logic [1:0] elapsed
);

    logic running;  // asn seen low at an earlier edge

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            elapsed <= 2'd0;
            running <= 1'b0;
        end else if (asn) begin
            elapsed <= 2'd0;    // idle between cycles
            running <= 1'b0;
        end else begin
            running <= 1'b1;
            // first low edge leaves it at zero
            if (running && elapsed != 2'd3) begin
                elapsed <= elapsed + 2'd1;
            end
        end
    end

endmodule

// File: rtl/dtack_select.sv
// ******************************
// DTACK selector
// wait-state compare or external
// acknowledge, registered DTACK
// ******************************
`timescale 1ns/1ps
`include "mapper_consts.svh"

module dtack_select
    import mapper_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       asn,
    input  logic       ext_dackn,
    input  decode_t    dec,
    input  logic [1:0] elapsed,
    output logic       dtackn
);

    logic       asn_l;      // asn at the previous edge
    logic       ext_l;      // external ack seen inside the cycle
    logic [1:0] wait_eff;
    logic       use_ext;
    logic       go;

    // unmapped and irq ack cycles take the fastest path
    assign wait_eff = dec.none ? 2'd0 : dec.wait_code;
    assign use_ext  = wait_eff == `MAP_WAIT_EXT;
    assign go       = use_ext ? ext_l : (elapsed >= wait_eff);

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            asn_l  <= 1'b1;
            ext_l  <= 1'b0;
            dtackn <= 1'b1;
        end else begin
            asn_l <= asn;
            ext_l <= ~asn & ~ext_dackn;
            if (asn) begin
                dtackn <= 1'b1;     // release right after the strobe
            end else if (!asn_l && go) begin
                dtackn <= 1'b0;     // held until asn rises
            end
        end
    end

endmodule

// File: rtl/mapper_consts.svh
// ******************************
// address mapper constants
// region count, register count,
// address width, register indices
// and special codes
// ******************************
`ifndef MAPPER_CONSTS_SVH
`define MAPPER_CONSTS_SVH

// eight decoded regions
`define MAP_REGIONS    8

// byte register bank
`define MAP_NREGS      32
`define MAP_IDX_W      5    // index from addr[5:1]

// word address, bits 23 down to 1
`define MAP_AW         23

// region r: size/wait at base+2r, base byte at base+2r+1
`define MAP_CFG_BASE   16

`define MAP_WAIT_EXT   2'd3     // dtack from external pin
`define MAP_FC_IACK    3'b111   // interrupt acknowledge

`endif

// File: rtl/mapper_pkg.sv
// ******************************
// mapper types
// bus request, region config and
// decode result structs
// ******************************
`include "mapper_consts.svh"

package mapper_pkg;

    // 68000 side of the bus, one cycle's worth of signals
    typedef struct packed {
        logic [`MAP_AW:1] addr;     // word address
        logic             asn;      // address strobe
        logic [1:0]       dsn;      // upper/lower data strobes
        logic             rnw;
        logic [2:0]       fc;       // function code
        logic [15:0]      wdata;
    } bus_req_t;

    // one region, unpacked from two bank bytes
    typedef struct packed {
        logic [7:0] base;       // upper address bits
        logic [1:0] size;       // 64k, 128k, 512k, 2M
        logic [1:0] wait_code;  // 1..3 cycles or external
    } region_cfg_t;

    typedef region_cfg_t [`MAP_REGIONS-1:0] region_cfg_arr_t;

    // matcher result
    typedef struct packed {
        logic [`MAP_REGIONS-1:0] active;    // one-hot or zero
        logic                    none;      // no region hit
        logic [1:0]              wait_code; // winner's wait field
    } decode_t;

endpackage

// File: rtl/mapper_regs.sv
// ******************************
// mapper register bank
// 32 bytes written from the CPU
// on unmapped cycles, read-back
// and region config unpacking
// ******************************
`timescale 1ns/1ps
`include "mapper_consts.svh"

module mapper_regs
    import mapper_pkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  bus_req_t        req,
    input  logic            none,
    output region_cfg_arr_t cfg,
    output logic [15:0]     rdata
);

    logic [7:0]            regs [`MAP_NREGS];
    logic                  asn_l;   // asn at the previous edge
    logic [`MAP_IDX_W-1:0] idx;
    logic                  first;   // first edge of the bus cycle
    logic                  wr_en;
    logic                  rd_en;

    assign idx   = req.addr[`MAP_IDX_W:1];
    assign first = ~req.asn & asn_l;

    // only one byte per bus cycle, and only on the low lane
    assign wr_en = first & ~req.rnw & none & ~req.dsn[0];

    // second edge on, address is settled and decode is stable
    assign rd_en = ~req.asn & ~asn_l & req.rnw & none;

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            asn_l <= 1'b1;
        end else begin
            asn_l <= req.asn;
        end
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `MAP_NREGS; i++) begin
                regs[i] <= 8'h00;
            end
        end else if (wr_en) begin
            regs[idx] <= req.wdata[7:0];
        end
    end

    // read-back, zero extended to the bus width
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            rdata <= 16'h0000;
        end else if (rd_en) begin
            rdata <= {8'h00, regs[idx]};
        end
    end

    // size/wait byte: bits 3:2 wait, bits 1:0 size
    genvar r;
    generate
        for (r = 0; r < `MAP_REGIONS; r++) begin : g_unpack
            assign cfg[r].base      = regs[`MAP_CFG_BASE + 2*r + 1];
            assign cfg[r].size      = regs[`MAP_CFG_BASE + 2*r][1:0];
            assign cfg[r].wait_code = regs[`MAP_CFG_BASE + 2*r][3:2];
        end
    endgenerate

endmodule

// File: rtl/mapper_top.sv
// ******************************
// address mapper top level
// register bank, region matcher,
// access timer, DTACK selector
// ******************************
`timescale 1ns/1ps

module mapper_top
    import mapper_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  bus_req_t             req,
    input  logic                 ext_dackn,
    output logic                 cpu_dtackn,
    output logic [7:0]           active,
    output logic [15:0]          rdata
);

    region_cfg_arr_t cfg;
    decode_t         dec;
    logic [1:0]      elapsed;

    assign active = dec.active;

    mapper_regs mapper_regs_i (
        .clk   (clk),
        .rst   (rst),
        .req   (req),
        .none  (dec.none),
        .cfg   (cfg),
        .rdata (rdata)
    );

    region_match region_match_i (
        .req (req),
        .cfg (cfg),
        .dec (dec)
    );

    // runs regardless of the decode
    access_timer access_timer_i (
        .clk     (clk),
        .rst     (rst),
        .asn     (req.asn),
        .elapsed (elapsed)
    );

    dtack_select dtack_select_i (
        .clk       (clk),
        .rst       (rst),
        .asn       (req.asn),
        .ext_dackn (ext_dackn),
        .dec       (dec),
        .elapsed   (elapsed),
        .dtackn    (cpu_dtackn)
    );

endmodule

// File: rtl/region_match.sv
// ******************************
// region matcher
// base/size compare per region,
// lowest region wins
// ******************************
`timescale 1ns/1ps
`include "mapper_consts.svh"

module region_match
    import mapper_pkg::*;
(
    input  bus_req_t        req,
    input  region_cfg_arr_t cfg,
    output decode_t         dec
);

    logic [`MAP_REGIONS-1:0] hit;

    // number of compared bits shrinks as the region grows
    function automatic logic in_region(input logic [`MAP_AW:1] a, input region_cfg_t c);
        logic match;
        case (c.size)
            2'd0:    match = a[23:16] == c.base;        // 64 kB
            2'd1:    match = a[23:17] == c.base[7:1];   // 128 kB
            2'd2:    match = a[23:19] == c.base[7:3];   // 512 kB
            default: match = a[23:21] == c.base[7:5];   // 2 MB
        endcase
        return match;
    endfunction

    always_comb begin
        for (int r = 0; r < `MAP_REGIONS; r++) begin
            hit[r] = in_region(req.addr, cfg[r]);
        end
    end

    always_comb begin
        logic found;
        found         = 1'b0;
        dec.active    = '0;
        dec.wait_code = 2'd0;
        for (int r = 0; r < `MAP_REGIONS; r++) begin
            if (hit[r] && !found) begin
                found         = 1'b1;
                dec.active[r] = 1'b1;
                dec.wait_code = cfg[r].wait_code;
            end
        end
        if (req.fc == `MAP_FC_IACK) begin   // irq ack never maps
            dec.active = '0;
        end
        dec.none = dec.active == '0;
    end

endmodule

// File: tests/mapper_sva.sv
// ******************************
// mapper assertions
// DTACK release and no-fall rules,
// one-hot decode at the selector
// ******************************
`timescale 1ns/1ps

module mapper_sva
    import mapper_pkg::*;
(
    input logic    clk,
    input logic    rst,
    input logic    asn,
    input logic    dtackn,
    input decode_t dec
);

    // strobe high at an edge means dtack is back high by the next one
    a_release: assert property (@(posedge clk) disable iff (rst) asn |=> dtackn)
        else $error("dtackn still low one cycle after asn went high");

    a_no_fall: assert property (@(posedge clk) disable iff (rst)
        $fell(dtackn) |-> !$past(asn))
        else $error("dtackn fell while asn was high");

    a_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(dec.active))
        else $error("decode active vector has more than one bit set");

endmodule

// decode arrives here unchanged from the matcher
bind dtack_select mapper_sva mapper_sva_i (
    .clk    (clk),
    .rst    (rst),
    .asn    (asn),
    .dtackn (dtackn),
    .dec    (dec)
);

// File: tests/mapper_tb.sv
// ******************************
// address mapper testbench
// seeded random bus cycles, model
// of the bank, decode and DTACK
// ******************************
`timescale 1ns/1ps
`include "mapper_consts.svh"

module mapper_tb
    import mapper_pkg::*;
();

    localparam int          ROUNDS    = 3;
    localparam int          RAND_N    = 80;
    localparam int          DTACK_MAX = 8;      // edges allowed per bus cycle
    localparam logic [2:0]  FC_SDATA  = 3'b101; // supervisor data
    localparam int          N_BUS     = 4 * `MAP_NREGS + ROUNDS * (3 * `MAP_REGIONS + RAND_N);
    localparam int          LIMIT     = 2 * N_BUS * (DTACK_MAX + 3);

    logic        clk;
    logic        rst;
    bus_req_t    req;
    logic        ext_dackn;
    logic        cpu_dtackn;
    logic [7:0]  active;
    logic [15:0] rdata;
    logic [7:0]  model [`MAP_NREGS];
    int          cycles;

    mapper_top mapper_top_i (
        .clk        (clk),
        .rst        (rst),
        .req        (req),
        .ext_dackn  (ext_dackn),
        .cpu_dtackn (cpu_dtackn),
        .active     (active),
        .rdata      (rdata)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT) begin
            abort_run($sformatf("simulation timed out after %0d clock cycles", cycles));
        end
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            abort_run($sformatf("[FAIL] %s expected 0x%0h actual 0x%0h", name, exp, act));
        end
    endtask

    // lowest region whose top address bits equal its base wins
    function automatic void model_decode(input logic [`MAP_AW:1] a, input logic [2:0] fc,
                                         output logic [7:0] act, output logic none,
                                         output logic [1:0] wc);
        int         sh;
        logic [7:0] sz_wait;
        logic [7:0] base;
        act  = '0;
        none = 1'b1;
        wc   = 2'd0;
        if (fc == `MAP_FC_IACK) return;
        for (int r = 0; r < `MAP_REGIONS; r++) begin
            sz_wait = model[`MAP_CFG_BASE + 2 * r];
            base    = model[`MAP_CFG_BASE + 2 * r + 1];
            case (sz_wait[1:0])
                2'd0:    sh = 0;    // 64 kB
                2'd1:    sh = 1;
                2'd2:    sh = 3;
                default: sh = 5;    // 2 MB
            endcase
            if (none && (a[23:16] >> sh) == (base >> sh)) begin
                act[r] = 1'b1;
                none   = 1'b0;
                wc     = sz_wait[3:2];
            end
        end
    endfunction

    task automatic bus_cycle(input string name, input logic [`MAP_AW:1] addr, input logic rnw,
                             input logic [2:0] fc, input logic [1:0] dsn, input logic [15:0] wdata);
        logic [7:0] act_exp;
        logic [7:0] act_post;
        logic       none_pre;
        logic       none_post;
        logic [1:0] wc;
        logic [4:0] idx;
        int         delay;
        int         lat;
        int         n;
        idx = addr[5:1];
        model_decode(addr, fc, act_exp, none_pre, wc);
        // write lands on the first edge, dtack then follows the new config
        if (!rnw && none_pre && !dsn[0]) begin
            model[idx] = wdata[7:0];
        end
        model_decode(addr, fc, act_post, none_post, wc);
        delay = $urandom_range(0, 4);
        lat   = (wc == `MAP_WAIT_EXT) ? delay + 2 : wc + 2;
        @(posedge clk);
        req.addr  <= addr;
        req.rnw   <= rnw;
        req.fc    <= fc;
        req.dsn   <= dsn;
        req.wdata <= wdata;
        req.asn   <= 1'b0;
        if (delay == 0) ext_dackn <= 1'b0;
        @(negedge clk);
        check({name, " active"}, act_exp, active);
        check({name, " dtackn idle"}, 1, cpu_dtackn);
        n = 0;
        while (cpu_dtackn) begin
            if (n >= DTACK_MAX) begin
                abort_run($sformatf("cpu_dtackn never fell in %s cycle at 0x%06h",
                                    name, {addr, 1'b0}));
            end
            @(posedge clk);
            n++;
            if (n == delay) ext_dackn <= 1'b0;   // external ack after a random wait
            @(negedge clk);
        end
        check({name, " dtack latency"}, lat, n);
        check({name, " active after"}, act_post, active);  // config write already landed
        if (rnw && none_post) check({name, " rdata"}, {8'h00, model[idx]}, rdata);
        @(posedge clk);
        req.asn   <= 1'b1;
        ext_dackn <= 1'b1;
        @(posedge clk);
        @(negedge clk);
        check({name, " dtackn release"}, 1, cpu_dtackn);
    endtask

    // walks the upper byte until the model finds a hole in the map
    task automatic find_unmapped(input logic [4:0] idx, output logic [`MAP_AW:1] addr);
        logic [7:0] hb;
        logic [7:0] act;
        logic       none;
        logic [1:0] wc;
        hb   = 8'($urandom);
        none = 1'b0;
        for (int k = 0; k < 256 && !none; k++) begin
            addr = {hb, 10'($urandom), idx};
            model_decode(addr, FC_SDATA, act, none, wc);
            hb = hb + 8'd1;
        end
        if (!none) abort_run("no unmapped address left for a register access");
    endtask

    task automatic write_reg(input logic [4:0] idx, input logic [7:0] val);
        logic [`MAP_AW:1] addr;
        find_unmapped(idx, addr);
        bus_cycle("write_reg", addr, 1'b0, FC_SDATA, 2'b00, {8'($urandom), val});
    endtask

    task automatic read_reg(input logic [4:0] idx);
        logic [`MAP_AW:1] addr;
        find_unmapped(idx, addr);
        bus_cycle("read_reg", addr, 1'b1, FC_SDATA, 2'b00, 16'($urandom));
    endtask

    // all size codes every round, wait codes rotate
    task automatic program_regions(input int round);
        logic [7:0] base;
        base = 8'($urandom);
        for (int r = 0; r < `MAP_REGIONS; r++) begin
            write_reg(5'(`MAP_CFG_BASE + 2 * r), {4'($urandom), 2'(r / 2 + round), 2'(r)});
            if ($urandom_range(0, 1) == 0) base = 8'($urandom);  // else overlap previous
            write_reg(5'(`MAP_CFG_BASE + 2 * r + 1), base);
        end
    endtask

    task automatic random_cycles(input int count);
        logic [7:0] hb;
        int         r;
        for (int i = 0; i < count; i++) begin
            r  = $urandom_range(0, `MAP_REGIONS - 1);
            hb = model[`MAP_CFG_BASE + 2 * r + 1] ^ 8'($urandom_range(0, 7));
            if ($urandom_range(0, 1) == 0) hb = 8'($urandom);
            bus_cycle("random", {hb, 15'($urandom)}, 1'($urandom), 3'($urandom),
                      2'($urandom), 16'($urandom));
        end
    endtask

    initial begin
        clk       = 1'b0;
        rst       = 1'b1;
        req.addr  = '0;
        req.asn   = 1'b1;
        req.dsn   = 2'b11;
        req.rnw   = 1'b1;
        req.fc    = 3'b000;
        req.wdata = '0;
        ext_dackn = 1'b1;
        cycles    = 0;
        for (int i = 0; i < `MAP_NREGS; i++) model[i] = 8'h00;
        void'($urandom(29));
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        for (int i = 0; i < `MAP_NREGS; i++) write_reg(5'(i), 8'($urandom));
        for (int i = 0; i < `MAP_NREGS; i++) write_reg(5'($urandom), 8'($urandom));
        for (int i = 0; i < `MAP_NREGS; i++) read_reg(5'(i));
        for (int round = 0; round < ROUNDS; round++) begin
            program_regions(round);
            // irq ack right on each region base
            for (int r = 0; r < `MAP_REGIONS; r++) begin
                bus_cycle("iack", {model[`MAP_CFG_BASE + 2 * r + 1], 15'($urandom)},
                          1'b1, `MAP_FC_IACK, 2'b11, 16'h0000);
            end
            random_cycles(RAND_N);
        end
        for (int i = 0; i < `MAP_NREGS; i++) read_reg(5'(i));
        $display("TB PASSED");
        $finish;
    end

endmodule
